/* rtl/itm_pkg.sv */
package itm_pkg;

   // global timestamp and core program counter
   localparam int ts_width = 16;
   localparam int pc_width = 32;

   // sequential run length, count 0 means a single instruction
   localparam int count_width = 8;

   // uncompressed record is timestamp then pc
   localparam int raw_width = ts_width + pc_width;

   // compressed record is timestamp, pc, count
   localparam int rec_width = raw_width + count_width;

   // history kept in front of a trigger
   localparam int trigger_delay = 4;

   // output buffer
   localparam int fifo_depth = 8;
   localparam int fifo_addr_width = $clog2(fifo_depth);

   // configuration bus
   localparam int wb_adr_width = 4;
   localparam int wb_data_width = 32;

   // register select from address bits 3:2
   typedef enum logic [1:0] {
      conf_ctrl   = 2'd0,
      conf_start  = 2'd1,
      conf_stop   = 2'd2,
      conf_status = 2'd3
   } conf_addr_e;

   // run compression
   typedef enum logic {
      comp_idle,
      comp_accum
   } comp_state_e;

endpackage

/* rtl/itm_trace_collector.sv */
`timescale 1ns/1ps

module itm_trace_collector (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [itm_pkg::ts_width-1:0]    timestamp,
   input  logic                            retire_valid,
   input  logic [itm_pkg::pc_width-1:0]    retire_pc,
   output logic                            raw_valid,
   output logic [itm_pkg::raw_width-1:0]   raw_record
);

   // one record per retired instruction
   always_ff @(posedge clk) begin
      if (reset) begin
         raw_valid <= 1'b0;
      end else begin
         raw_valid <= retire_valid;
      end
   end

   // timestamp in the upper bits, pc below
   // idle cycles keep the last record
   always_ff @(posedge clk) begin
      if (retire_valid) begin
         raw_record <= {timestamp, retire_pc};
      end
   end

endmodule

/* rtl/itm_delay_sr.sv */
`timescale 1ns/1ps

module itm_delay_sr (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            in_valid,
   input  logic [itm_pkg::raw_width-1:0]   in_record,
   output logic                            out_valid,
   output logic [itm_pkg::raw_width-1:0]   out_record
);

   logic [itm_pkg::trigger_delay-1:0] valid_sr;
   logic [itm_pkg::raw_width-1:0]     record_sr [itm_pkg::trigger_delay];

   // valid bits flushed on reset
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_sr <= '0;
      end else begin
         valid_sr <= {valid_sr[itm_pkg::trigger_delay-2:0], in_valid};
      end
   end

   // stage 0 takes the input, higher stages follow
   always_ff @(posedge clk) begin
      record_sr[0] <= in_record;
      for (int i = 1; i < itm_pkg::trigger_delay; i++) begin
         record_sr[i] <= record_sr[i-1];
      end
   end

   assign out_valid  = valid_sr[itm_pkg::trigger_delay-1];
   assign out_record = record_sr[itm_pkg::trigger_delay-1];

endmodule

/* rtl/itm_trace_qualificator.sv */
`timescale 1ns/1ps

module itm_trace_qualificator (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            raw_valid,
   input  logic [itm_pkg::raw_width-1:0]   raw_record,
   input  logic                            conf_enable,
   input  logic [itm_pkg::pc_width-1:0]    start_pc,
   input  logic [itm_pkg::pc_width-1:0]    stop_pc,
   input  logic                            trigger_in,
   output logic                            trace_enable,
   output logic                            trigger_out
);

   logic [itm_pkg::pc_width-1:0] raw_pc;
   logic                         start_hit;
   logic                         stop_hit;

   // pc sits in the low bits of the raw record
   assign raw_pc = raw_record[itm_pkg::pc_width-1:0];

   // start on a pc match or an external trigger
   // only while the unit is enabled
   assign start_hit = conf_enable & ((raw_valid & (raw_pc == start_pc)) | trigger_in);

   // stop on a pc match
   assign stop_hit = raw_valid & (raw_pc == stop_pc);

   // decision is made on the undelayed stream,
   // so the delay line still holds the history in front of it
   always_ff @(posedge clk) begin
      if (reset) begin
         trace_enable <= 1'b0;
         trigger_out  <= 1'b0;
      end else begin
         // pulse only when trace actually starts,
         // a start match while already tracing is silent
         trigger_out <= start_hit & ~trace_enable;

         if (!conf_enable) begin
            trace_enable <= 1'b0;
         end else if (start_hit) begin
            // start wins over a stop in the same cycle
            trace_enable <= 1'b1;
         end else if (stop_hit) begin
            trace_enable <= 1'b0;
         end
      end
   end

endmodule

/* rtl/itm_trace_compression.sv */
`timescale 1ns/1ps

module itm_trace_compression (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            in_valid,
   input  logic [itm_pkg::raw_width-1:0]   in_record,
   input  logic                            trace_enable,
   output logic                            comp_valid,
   output logic [itm_pkg::rec_width-1:0]   comp_record
);

   itm_pkg::comp_state_e state;

   // pending run
   logic [itm_pkg::ts_width-1:0]    run_ts;
   logic [itm_pkg::pc_width-1:0]    run_pc;
   logic [itm_pkg::pc_width-1:0]    last_pc;
   logic [itm_pkg::count_width-1:0] run_count;

   logic [itm_pkg::ts_width-1:0] in_ts;
   logic [itm_pkg::pc_width-1:0] in_pc;
   logic gated;
   logic extend;
   logic load_run;
   logic emit;

   assign in_ts = in_record[itm_pkg::raw_width-1:itm_pkg::pc_width];
   assign in_pc = in_record[itm_pkg::pc_width-1:0];

   // only records leaving the delay line while enabled are traced
   assign gated = in_valid & trace_enable;

   // next sequential pc and the counter still has room
   assign extend = (state == itm_pkg::comp_accum) & gated
                 & (in_pc == last_pc + 4)
                 & (run_count != {itm_pkg::count_width{1'b1}});

   // any other traced record opens a new run
   assign load_run = gated & ~extend;

   // run ends on a break, a saturated counter or trace stop
   assign emit = (state == itm_pkg::comp_accum) & ((gated & ~extend) | ~trace_enable);

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= itm_pkg::comp_idle;
         comp_valid <= 1'b0;
      end else begin
         comp_valid <= emit;
         if (load_run) begin
            state <= itm_pkg::comp_accum;
         end else if (!trace_enable) begin
            // flushed run leaves nothing pending
            state <= itm_pkg::comp_idle;
         end
      end
   end

   // run bookkeeping and the output record
   always_ff @(posedge clk) begin
      if (emit) begin
         comp_record <= {run_ts, run_pc, run_count};
      end
      if (load_run) begin
         run_ts    <= in_ts;
         run_pc    <= in_pc;
         last_pc   <= in_pc;
         run_count <= '0;
      end else if (extend) begin
         last_pc   <= in_pc;
         run_count <= run_count + 1'b1;
      end
   end

endmodule

/* rtl/itm_conf_regs.sv */
`timescale 1ns/1ps

module itm_conf_regs (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                wb_cyc,
   input  logic                                wb_stb,
   input  logic                                wb_we,
   input  logic [itm_pkg::wb_adr_width-1:0]    wb_adr,
   input  logic [itm_pkg::wb_data_width-1:0]   wb_dat_w,
   input  logic                                trace_active,
   input  logic                                overflow,
   output logic [itm_pkg::wb_data_width-1:0]   wb_dat_r,
   output logic                                wb_ack,
   output logic                                conf_enable,
   output logic [itm_pkg::pc_width-1:0]        start_pc,
   output logic [itm_pkg::pc_width-1:0]        stop_pc
);

   itm_pkg::conf_addr_e sel;
   logic request;
   logic wr_en;
   logic overflow_sticky;

   // word select from address bits 3:2
   assign sel = itm_pkg::conf_addr_e'(wb_adr[3:2]);

   // new request, not the one already being acked
   assign request = wb_cyc & wb_stb & ~wb_ack;

   // write lands on the edge where the master sees ack
   assign wr_en = wb_ack & wb_cyc & wb_stb & wb_we;

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_ack          <= 1'b0;
         conf_enable     <= 1'b0;
         start_pc        <= '0;
         stop_pc         <= '0;
         overflow_sticky <= 1'b0;
      end else begin
         wb_ack <= request;

         if (wr_en && sel == itm_pkg::conf_ctrl) begin
            conf_enable <= wb_dat_w[0];
         end
         if (wr_en && sel == itm_pkg::conf_start) begin
            start_pc <= wb_dat_w;
         end
         if (wr_en && sel == itm_pkg::conf_stop) begin
            stop_pc <= wb_dat_w;
         end

         // new overflow beats a clear in the same cycle
         if (overflow) begin
            overflow_sticky <= 1'b1;
         end else if (wr_en && sel == itm_pkg::conf_status && wb_dat_w[0]) begin
            overflow_sticky <= 1'b0;
         end
      end
   end

   // read data is captured with the request, valid with ack
   always_ff @(posedge clk) begin
      if (request) begin
         case (sel)
            itm_pkg::conf_ctrl:  wb_dat_r <= {{(itm_pkg::wb_data_width-1){1'b0}}, conf_enable};
            itm_pkg::conf_start: wb_dat_r <= start_pc;
            itm_pkg::conf_stop:  wb_dat_r <= stop_pc;
            default: begin
               wb_dat_r <= {{(itm_pkg::wb_data_width-2){1'b0}}, trace_active, overflow_sticky};
            end
         endcase
      end
   end

endmodule

/* rtl/itm_trace_fifo.sv */
`timescale 1ns/1ps

module itm_trace_fifo (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            wr_valid,
   input  logic [itm_pkg::rec_width-1:0]   wr_record,
   input  logic                            trace_ready,
   output logic                            trace_valid,
   output logic [itm_pkg::rec_width-1:0]   trace_data,
   output logic                            overflow
);

   logic [itm_pkg::rec_width-1:0]       mem [itm_pkg::fifo_depth];
   logic [itm_pkg::fifo_addr_width-1:0] wr_ptr;
   logic [itm_pkg::fifo_addr_width-1:0] rd_ptr;
   logic [itm_pkg::fifo_addr_width:0]   count;
   logic full;
   logic wr_en;
   logic rd_en;

   assign full  = (count == itm_pkg::fifo_depth);
   assign wr_en = wr_valid & ~full;
   assign rd_en = trace_valid & trace_ready;

   // head of the buffer, stable until popped
   assign trace_valid = (count != '0);
   assign trace_data  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end else begin
         // trace path never waits, a full buffer drops the record
         overflow <= wr_valid & full;
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + wr_en - rd_en;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_record;
      end
   end

endmodule

/* rtl/itm.sv */
`timescale 1ns/1ps

module itm (
   input  logic                                clk,
   input  logic                                reset,
   input  logic [itm_pkg::ts_width-1:0]        timestamp,
   input  logic                                retire_valid,
   input  logic [itm_pkg::pc_width-1:0]        retire_pc,
   input  logic                                trigger_in,
   output logic                                trigger_out,
   input  logic                                wb_cyc,
   input  logic                                wb_stb,
   input  logic                                wb_we,
   input  logic [itm_pkg::wb_adr_width-1:0]    wb_adr,
   input  logic [itm_pkg::wb_data_width-1:0]   wb_dat_w,
   output logic [itm_pkg::wb_data_width-1:0]   wb_dat_r,
   output logic                                wb_ack,
   output logic [itm_pkg::rec_width-1:0]       trace_data,
   output logic                                trace_valid,
   input  logic                                trace_ready
);

   // trace path
   logic                          raw_valid;
   logic [itm_pkg::raw_width-1:0] raw_record;
   logic                          dly_valid;
   logic [itm_pkg::raw_width-1:0] dly_record;
   logic                          comp_valid;
   logic [itm_pkg::rec_width-1:0] comp_record;
   logic                          trace_enable;
   logic                          fifo_overflow;

   // configuration
   logic                         conf_enable;
   logic [itm_pkg::pc_width-1:0] start_pc;
   logic [itm_pkg::pc_width-1:0] stop_pc;

   itm_trace_collector u_trace_collector (
      .clk          (clk),
      .reset        (reset),
      .timestamp    (timestamp),
      .retire_valid (retire_valid),
      .retire_pc    (retire_pc),
      .raw_valid    (raw_valid),
      .raw_record   (raw_record)
   );

   // history in front of the trigger
   itm_delay_sr u_delay_sr (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (raw_valid),
      .in_record  (raw_record),
      .out_valid  (dly_valid),
      .out_record (dly_record)
   );

   // qualifies on the undelayed stream
   itm_trace_qualificator u_trace_qualificator (
      .clk          (clk),
      .reset        (reset),
      .raw_valid    (raw_valid),
      .raw_record   (raw_record),
      .conf_enable  (conf_enable),
      .start_pc     (start_pc),
      .stop_pc      (stop_pc),
      .trigger_in   (trigger_in),
      .trace_enable (trace_enable),
      .trigger_out  (trigger_out)
   );

   itm_trace_compression u_trace_compression (
      .clk          (clk),
      .reset        (reset),
      .in_valid     (dly_valid),
      .in_record    (dly_record),
      .trace_enable (trace_enable),
      .comp_valid   (comp_valid),
      .comp_record  (comp_record)
   );

   itm_trace_fifo u_trace_fifo (
      .clk         (clk),
      .reset       (reset),
      .wr_valid    (comp_valid),
      .wr_record   (comp_record),
      .trace_ready (trace_ready),
      .trace_valid (trace_valid),
      .trace_data  (trace_data),
      .overflow    (fifo_overflow)
   );

   // trace_enable doubles as the trace active status
   itm_conf_regs u_conf_regs (
      .clk          (clk),
      .reset        (reset),
      .wb_cyc       (wb_cyc),
      .wb_stb       (wb_stb),
      .wb_we        (wb_we),
      .wb_adr       (wb_adr),
      .wb_dat_w     (wb_dat_w),
      .trace_active (trace_enable),
      .overflow     (fifo_overflow),
      .wb_dat_r     (wb_dat_r),
      .wb_ack       (wb_ack),
      .conf_enable  (conf_enable),
      .start_pc     (start_pc),
      .stop_pc      (stop_pc)
   );

endmodule

/* bench/itm_chk.sv */
`timescale 1ns/1ps

module itm_chk (
   input logic                            clk,
   input logic                            reset,
   input logic                            wb_ack,
   input logic                            trace_valid,
   input logic                            trace_ready,
   input logic [itm_pkg::rec_width-1:0]   trace_data,
   input logic                            trigger_out
);

   // failed assertions, summed into the testbench error count
   int fails = 0;

   // ack is a single cycle
   ack_one_cycle: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
      else begin
         fails++;
         $error("wb_ack held longer than one cycle");
      end

   // stalled record held stable
   data_stable: assert property (@(posedge clk) disable iff (reset)
      trace_valid && !trace_ready |=> trace_valid && $stable(trace_data))
      else begin
         fails++;
         $error("trace_data changed while stalled");
      end

   // trigger is a pulse
   trig_pulse: assert property (@(posedge clk) disable iff (reset) trigger_out |=> !trigger_out)
      else begin
         fails++;
         $error("trigger_out longer than one cycle");
      end

endmodule

bind itm itm_chk chk_inst (
   .clk         (clk),
   .reset       (reset),
   .wb_ack      (wb_ack),
   .trace_valid (trace_valid),
   .trace_ready (trace_ready),
   .trace_data  (trace_data),
   .trigger_out (trigger_out)
);

/* bench/itm_monitor.sv */
`timescale 1ns/1ps

module itm_monitor (
   input logic                                clk,
   input logic                                reset,
   input logic [itm_pkg::ts_width-1:0]        timestamp,
   input logic                                retire_valid,
   input logic [itm_pkg::pc_width-1:0]        retire_pc,
   input logic                                trigger_in,
   input logic                                trigger_out,
   input logic                                wb_cyc,
   input logic                                wb_stb,
   input logic                                wb_we,
   input logic [itm_pkg::wb_adr_width-1:0]    wb_adr,
   input logic [itm_pkg::wb_data_width-1:0]   wb_dat_w,
   input logic                                wb_ack,
   input logic [itm_pkg::rec_width-1:0]       trace_data,
   input logic                                trace_valid,
   input logic                                trace_ready
);

   // set by the testbench before each test
   string test_name = "none";
   int    errors = 0;
   int    matched = 0;
   int    sat_seen = 0;
   int    trig_seen = 0;
   int    pending = 0;
   bit    ovf_seen = 1'b0;

   // records expected on the output, oldest first
   logic [itm_pkg::rec_width-1:0] expq [$];

   // model of the configuration
   logic                         m_cfg_en;
   logic [itm_pkg::pc_width-1:0] m_start;
   logic [itm_pkg::pc_width-1:0] m_stop;
   // model of collector and delay line
   logic                          m_raw_v;
   logic [itm_pkg::raw_width-1:0] m_raw;
   logic                          dly_v [itm_pkg::trigger_delay];
   logic [itm_pkg::raw_width-1:0] dly_r [itm_pkg::trigger_delay];
   // model of qualifier
   logic m_en;
   logic m_trig;
   // model of compression
   logic                            st_acc;
   logic [itm_pkg::ts_width-1:0]    run_ts;
   logic [itm_pkg::pc_width-1:0]    run_pc;
   logic [itm_pkg::pc_width-1:0]    last_pc;
   logic [itm_pkg::count_width-1:0] run_cnt;
   logic                            cv;
   logic [itm_pkg::rec_width-1:0]   crec;

   always @(posedge clk) begin : model
      logic                          full;
      logic [itm_pkg::rec_width-1:0] exp;
      logic [itm_pkg::pc_width-1:0]  d_pc;
      logic [itm_pkg::ts_width-1:0]  d_ts;
      logic [itm_pkg::pc_width-1:0]  r_pc;
      logic gated;
      logic ext;
      logic brk;
      logic hit;
      logic stop_hit;
      if (reset) begin
         m_cfg_en = 1'b0;
         m_start = '0;
         m_stop = '0;
         m_raw_v = 1'b0;
         m_en = 1'b0;
         m_trig = 1'b0;
         st_acc = 1'b0;
         cv = 1'b0;
         for (int i = 0; i < itm_pkg::trigger_delay; i++) begin
            dly_v[i] = 1'b0;
         end
         expq.delete();
      end else begin
         // fifo full is judged before this edge's pop
         full = (expq.size() >= itm_pkg::fifo_depth);
         if (trace_valid && trace_ready) begin
            if (expq.size() == 0) begin
               $display("%s: record %h came out with nothing expected", test_name, trace_data);
               errors++;
            end else begin
               exp = expq.pop_front();
               if (trace_data !== exp) begin
                  $display("error %s: expected %h actual %h", test_name, exp, trace_data);
                  errors++;
               end else begin
                  matched++;
               end
               if (exp[itm_pkg::count_width-1:0] == 8'd255) begin
                  sat_seen++;
               end
            end
         end
         // write into the output buffer, dropped when full
         if (cv) begin
            if (full) begin
               ovf_seen = 1'b1;
            end else begin
               expq.push_back(crec);
            end
         end
         if (trigger_out !== m_trig) begin
            $display("error %s: expected trigger_out %b actual %b", test_name, m_trig,
                     trigger_out);
            errors++;
         end
         if (trigger_out) begin
            trig_seen++;
         end
         // run compression on the delayed stream
         d_pc = dly_r[itm_pkg::trigger_delay-1][itm_pkg::pc_width-1:0];
         d_ts = dly_r[itm_pkg::trigger_delay-1][itm_pkg::raw_width-1:itm_pkg::pc_width];
         gated = dly_v[itm_pkg::trigger_delay-1] & m_en;
         ext = st_acc & gated & (d_pc == last_pc + 32'd4) & (run_cnt != 8'd255);
         brk = gated & ~ext;
         cv = st_acc & (brk | ~m_en);
         if (cv) begin
            crec = {run_ts, run_pc, run_cnt};
         end
         if (brk) begin
            st_acc = 1'b1;
            run_ts = d_ts;
            run_pc = d_pc;
            last_pc = d_pc;
            run_cnt = '0;
         end else if (ext) begin
            last_pc = d_pc;
            run_cnt = run_cnt + 8'd1;
         end else if (!m_en) begin
            st_acc = 1'b0;
         end
         // start and stop seen on the undelayed stream
         r_pc = m_raw[itm_pkg::pc_width-1:0];
         hit = m_cfg_en & ((m_raw_v & (r_pc == m_start)) | trigger_in);
         stop_hit = m_raw_v & (r_pc == m_stop);
         m_trig = hit & ~m_en;
         if (!m_cfg_en) begin
            m_en = 1'b0;
         end else if (hit) begin
            m_en = 1'b1;
         end else if (stop_hit) begin
            m_en = 1'b0;
         end
         // delay line
         for (int i = itm_pkg::trigger_delay - 1; i > 0; i--) begin
            dly_v[i] = dly_v[i-1];
            dly_r[i] = dly_r[i-1];
         end
         dly_v[0] = m_raw_v;
         dly_r[0] = m_raw;
         // collector
         m_raw_v = retire_valid;
         if (retire_valid) begin
            m_raw = {timestamp, retire_pc};
         end
         // register writes land on the ack edge
         if (wb_ack && wb_cyc && wb_stb && wb_we) begin
            case (wb_adr[3:2])
               2'd0: m_cfg_en = wb_dat_w[0];
               2'd1: m_start = wb_dat_w;
               2'd2: m_stop = wb_dat_w;
               default: ;
            endcase
         end
      end
      pending = expq.size();
   end

endmodule

/* bench/itm_tb.sv */
`timescale 1ns/1ps

module itm_tb;

   logic                                clk;
   logic                                reset;
   logic [itm_pkg::ts_width-1:0]        timestamp;
   logic                                retire_valid;
   logic [itm_pkg::pc_width-1:0]        retire_pc;
   logic                                trigger_in;
   logic                                trigger_out;
   logic                                wb_cyc;
   logic                                wb_stb;
   logic                                wb_we;
   logic [itm_pkg::wb_adr_width-1:0]    wb_adr;
   logic [itm_pkg::wb_data_width-1:0]   wb_dat_w;
   logic [itm_pkg::wb_data_width-1:0]   wb_dat_r;
   logic                                wb_ack;
   logic [itm_pkg::rec_width-1:0]       trace_data;
   logic                                trace_valid;
   logic                                trace_ready;

   logic [31:0] rng = 32'd2;
   logic [31:0] pc;
   int errors = 0;
   int tests_run = 0;
   int tests_failed = 0;
   int err_base = 0;
   int trig_base = 0;
   int sat_base = 0;
   int match_base = 0;

   itm itm_inst (.*);

   itm_monitor mon (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // free running global time base
   always @(negedge clk) begin
      timestamp <= timestamp + 1'b1;
   end

   function automatic logic [31:0] next_random();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // register checks, record checks and bound assertions together
   function automatic int total_errors();
      return errors + mon.errors + itm_inst.chk_inst.fails;
   endfunction

   task automatic fail_now(input string what);
      $display("timeout waiting for %s", what);
      $display("TEST FAILED");
      $finish;
   endtask

   // one classic cycle, ack expected within a few clocks
   task automatic wb_access(input logic we, input logic [3:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
      int t;
      @(negedge clk);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = we;
      wb_adr = adr;
      wb_dat_w = wdat;
      t = 0;
      while (!wb_ack) begin
         @(negedge clk);
         t++;
         if (t > 20) begin
            fail_now("wb_ack");
         end
      end
      rdat = wb_dat_r;
      // drop the strobe after the ack edge
      @(negedge clk);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
   endtask

   task automatic wb_write(input logic [3:0] adr, input logic [31:0] wdat);
      logic [31:0] unused;
      wb_access(1'b1, adr, wdat, unused);
   endtask

   task automatic check_reg(input string name, input logic [3:0] adr,
                            input logic [31:0] mask, input logic [31:0] exp);
      logic [31:0] d;
      wb_access(1'b0, adr, 32'd0, d);
      if ((d & mask) !== exp) begin
         $display("error %s %s: expected %h actual %h", mon.test_name, name, exp, d & mask);
         errors++;
      end
   endtask

   // retirements with random gaps and jumps, ready random when asked
   task automatic stream(input int n, input int gap_pct, input int jump_pct,
                         input bit rand_ready);
      for (int i = 0; i < n; i++) begin
         @(negedge clk);
         if (next_random() % 100 < gap_pct) begin
            retire_valid = 1'b0;
         end else begin
            retire_valid = 1'b1;
            if (next_random() % 100 < jump_pct) begin
               pc = 32'h1000 + (next_random() % 64) * 4;
            end else begin
               pc = pc + 32'd4;
            end
            retire_pc = pc;
         end
         if (rand_ready) begin
            trace_ready = next_random() & 1;
         end
      end
      @(negedge clk);
      retire_valid = 1'b0;
   endtask

   // walk into the stop pc
   task automatic run_to_stop();
      pc = 32'h1ff4;
      stream(3, 0, 0, 1'b0);
   endtask

   task automatic pulse_trigger();
      @(negedge clk);
      trigger_in = 1'b1;
      @(negedge clk);
      trigger_in = 1'b0;
   endtask

   // let the pipeline flush, then empty the output
   task automatic drain();
      int t;
      @(negedge clk);
      retire_valid = 1'b0;
      trace_ready = 1'b1;
      t = 0;
      while (t < 12 || mon.pending != 0 || trace_valid) begin
         @(negedge clk);
         t++;
         if (t > 200) begin
            fail_now("output to drain");
         end
      end
   endtask

   task automatic begin_test(input string name);
      mon.test_name = name;
      mon.ovf_seen = 1'b0;
      err_base = total_errors();
      trig_base = mon.trig_seen;
      sat_base = mon.sat_seen;
      match_base = mon.matched;
   endtask

   task automatic end_test(input string name);
      int errs;
      errs = total_errors() - err_base;
      tests_run++;
      if (errs != 0) begin
         tests_failed++;
      end
      $display("test %s: %0d errors, %0d records matched so far", name, errs, mon.matched);
   endtask

   initial begin
      reset = 1'b1;
      timestamp = '0;
      retire_valid = 1'b0;
      retire_pc = '0;
      trigger_in = 1'b0;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      trace_ready = 1'b1;
      pc = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      begin_test("registers");
      check_reg("status after reset", 4'hc, 32'hffffffff, 32'd0);
      wb_write(4'h0, 32'd1);
      wb_write(4'h4, 32'h1000);
      wb_write(4'h8, 32'h2000);
      check_reg("ctrl", 4'h0, 32'hffffffff, 32'd1);
      check_reg("start", 4'h4, 32'hffffffff, 32'h1000);
      check_reg("stop", 4'h8, 32'hffffffff, 32'h2000);
      end_test("registers");

      // history before the start pc is part of the trace
      // sequential walk from 0x0fc0 crosses the start pc despite the gaps
      begin_test("compression");
      pc = 32'h0fc0;
      stream(32, 10, 0, 1'b0);
      stream(80, 15, 15, 1'b0);
      run_to_stop();
      drain();
      if (mon.matched == match_base) begin
         $display("compression: no record came out of the trace");
         errors++;
      end
      end_test("compression");

      begin_test("triggers");
      pc = 32'h0ff0;
      stream(8, 0, 0, 1'b0);
      run_to_stop();
      pc = 32'h0fe8;
      stream(8, 0, 0, 1'b0);
      run_to_stop();
      wb_write(4'h4, 32'hffff0000);
      pc = 32'h3000;
      pulse_trigger();
      stream(10, 0, 0, 1'b0);
      // trace running after the external trigger
      check_reg("trace active", 4'hc, 32'd2, 32'd2);
      run_to_stop();
      drain();
      if (mon.trig_seen - trig_base != 3) begin
         $display("error triggers: expected %0d actual %0d", 3, mon.trig_seen - trig_base);
         errors++;
      end
      end_test("triggers");

      // 600 sequential records split into 256, 256 and 88
      begin_test("saturation");
      pc = 32'h4000;
      pulse_trigger();
      stream(600, 0, 0, 1'b0);
      run_to_stop();
      drain();
      if (mon.sat_seen - sat_base != 2) begin
         $display("error saturation: expected %0d actual %0d", 2, mon.sat_seen - sat_base);
         errors++;
      end
      end_test("saturation");

      begin_test("backpressure");
      pulse_trigger();
      stream(80, 20, 20, 1'b1);
      run_to_stop();
      drain();
      // random ready keeps up, nothing dropped
      check_reg("no overflow with random ready", 4'hc, 32'd1, 32'd0);
      @(negedge clk);
      trace_ready = 1'b0;
      pulse_trigger();
      stream(40, 0, 100, 1'b0);
      run_to_stop();
      repeat (12) @(negedge clk);
      check_reg("overflow set", 4'hc, 32'd1, 32'd1);
      if (!mon.ovf_seen) begin
         $display("backpressure: the model saw no dropped record");
         errors++;
      end
      drain();
      wb_write(4'hc, 32'd1);
      check_reg("overflow cleared", 4'hc, 32'd1, 32'd0);
      end_test("backpressure");

      $display("%0d tests, %0d failed, %0d errors, %0d records matched", tests_run,
               tests_failed, total_errors(), mon.matched);
      if (tests_failed == 0 && total_errors() == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* flist.f */
rtl/itm_pkg.sv
rtl/itm_trace_collector.sv
rtl/itm_delay_sr.sv
rtl/itm_trace_qualificator.sv
rtl/itm_trace_compression.sv
rtl/itm_conf_regs.sv
rtl/itm_trace_fifo.sv
rtl/itm.sv
bench/itm_chk.sv
bench/itm_monitor.sv
bench/itm_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := itm_tb
FLIST     := flist.f
SRCS      := $(shell grep -v '^+' $(FLIST))
BIN       := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^TEST PASSED$$'

clean:
	rm -rf obj_dir
